// File: project.f
+incdir+verification
rtl/f2_bus_pkg.sv
rtl/f2_board_pkg.sv
rtl/address_decoder.sv
rtl/rom_fetch.sv
rtl/work_ram.sv
rtl/io_ports.sv
rtl/interrupt_controller.sv
rtl/bus_response.sv
rtl/f2_cpu_bus.sv
verification/tb_f2_cpu_bus.sv

// File: Makefile
SIM  := obj_dir/Vtb_f2_cpu_bus
SRCS := $(wildcard rtl/*.sv verification/*.sv verification/*.svh) project.f

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -j 0 -Mdir obj_dir \
		--top-module tb_f2_cpu_bus -f project.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verification/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// Bus cycle helpers

task automatic report_value(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    $display("** Error: %s = %0h, expected %0h", name, got, expected);
    errors++;
endtask

// Strobes stay low until dtack_n is seen low just before a rising edge
task automatic bus_cycle(input logic [23:0] byte_addr, input logic [1:0] ds_n,
                         input logic rw, input logic [15:0] wdata,
                         output logic [15:0] rdata);
    @(negedge clk);
    cpu_bus.addr  = byte_addr[23:1];
    cpu_bus.fc    = 3'b101;  // Supervisor data
    cpu_bus.rw    = rw;
    cpu_bus.wdata = wdata;
    cpu_bus.as_n  = 1'b0;
    cpu_bus.ds_n  = ds_n;
    @(posedge clk);
    while (dtack_n) @(posedge clk);
    rdata = data_in;
    @(negedge clk);
    cpu_bus.as_n = 1'b1;
    cpu_bus.ds_n = 2'b11;
endtask

task automatic bus_write(input logic [23:0] byte_addr, input logic [1:0] ds_n,
                         input logic [15:0] wdata);
    logic [15:0] unused;
    bus_cycle(byte_addr, ds_n, 1'b0, wdata, unused);
endtask

task automatic bus_read(input logic [23:0] byte_addr, input logic [1:0] ds_n,
                        output logic [15:0] data);
    bus_cycle(byte_addr, ds_n, 1'b1, 16'h0000, data);
endtask

// Level on A3:A1 with only the lower strobe
task automatic ack_irq(input logic [2:0] level);
    @(negedge clk);
    cpu_bus.addr = {20'hfffff, level};
    cpu_bus.fc   = 3'b111;
    cpu_bus.rw   = 1'b1;
    cpu_bus.as_n = 1'b0;
    cpu_bus.ds_n = 2'b10;
    @(negedge clk);
    cpu_bus.as_n = 1'b1;
    cpu_bus.ds_n = 2'b11;
    @(negedge clk);
endtask

task automatic report_test(input string name, input int start_errors);
    int test_errors;
    test_errors = errors + pending_errors - start_errors;
    if (test_errors != 0) begin
        tests_failed++;
    end
    $display("%-12s %s, %0d errors", name, test_errors == 0 ? "ok" : "FAILED", test_errors);
endtask

//////////////////////////////////////////////////
// Directed tests

task automatic work_ram_round_trip();
    logic [23:0] addr [32];
    logic [15:0] expected [32];
    logic [15:0] wdata;
    logic [15:0] data;
    int          start_errors;
    start_errors = errors + pending_errors;
    for (int i = 0; i < 32; i++) begin
        addr[i]     = {MAP.work_page, 10'($random(seed)), 5'(i), 1'b0};  // Unique by i
        expected[i] = 16'($random(seed));
        bus_write(addr[i], 2'b00, expected[i]);
        wdata = 16'($random(seed));
        if (i % 4 == 1) begin
            bus_write(addr[i], 2'b01, wdata);  // Upper byte only
            expected[i][15:8] = wdata[15:8];
        end else if (i % 4 == 3) begin
            bus_write(addr[i], 2'b10, wdata);
            expected[i][7:0] = wdata[7:0];
        end
    end
    for (int i = 0; i < 32; i++) begin
        bus_read(addr[i], 2'b00, data);
        if (data !== expected[i]) report_value("data_in", 32'(data), 32'(expected[i]));
    end
    report_test("work_ram", start_errors);
endtask

task automatic rom_reads();
    logic [23:0] byte_addr;
    logic [1:0]  ds_n;
    logic [26:0] exp_addr;
    logic [1:0]  exp_be;
    logic [15:0] data;
    logic        req_before;
    int          start_errors;
    start_errors = errors + pending_errors;
    for (int i = 0; i < 20; i++) begin
        byte_addr  = {MAP.rom_page, 15'($random(seed)), 1'b0};
        ds_n       = (i % 3 == 0) ? 2'b00 : (i % 3 == 1) ? 2'b01 : 2'b10;
        exp_addr   = ROM_BASE + {3'b000, byte_addr};
        exp_be     = ~ds_n;
        req_before = sdr_req;
        bus_read(byte_addr, ds_n, data);
        if (sdr_req === req_before) begin
            $display("No SDRAM request was raised for ROM address %h", byte_addr);
            errors++;
        end
        if (sdr_addr !== exp_addr) report_value("sdr_addr", 32'(sdr_addr), 32'(exp_addr));
        if (sdr_be !== exp_be) report_value("sdr_be", 32'(sdr_be), 32'(exp_be));
        if (data !== (exp_addr[15:0] ^ 16'h5a5a)) begin
            report_value("data_in", 32'(data), 32'(exp_addr[15:0] ^ 16'h5a5a));
        end
    end
    report_test("rom_fetch", start_errors);
endtask

// Start on top, then buttons, then the joystick bits reversed
function automatic logic [7:0] player_byte(input logic start_bit, input logic [7:0] joy);
    return {start_bit, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
endfunction

task automatic io_register_reads();
    logic [7:0]  value;
    logic [15:0] data;
    int          start_errors;
    start_errors = errors + pending_errors;
    @(negedge clk);
    dswa        = 8'($random(seed));
    dswb        = 8'($random(seed));
    joystick_p1 = 8'($random(seed));
    joystick_p2 = 8'($random(seed));
    start       = 2'($random(seed));
    coin        = 2'($random(seed));
    for (int idx = 0; idx < 8; idx++) begin
        case (idx)
            0: value = dswa;
            1: value = dswb;
            2: value = player_byte(start[0], joystick_p1);
            3: value = player_byte(start[1], joystick_p2);
            4: value = {4'b0000, coin, 2'b00};
            default: value = 8'h00;
        endcase
        bus_read({MAP.io_page, 12'h000, 3'(idx), 1'b0}, 2'b00, data);
        if (data !== {8'h00, ~value}) report_value("data_in", 32'(data), 32'({8'h00, ~value}));
    end
    report_test("io_ports", start_errors);
endtask

task automatic interrupt_priority();
    int start_errors;
    start_errors = errors + pending_errors;
    @(negedge clk);
    vblank = 1'b1;
    @(negedge clk);
    if (ipl_n !== 3'b111) report_value("ipl_n", 32'(ipl_n), 32'(3'b111));  // Rise ignored
    vblank = 1'b0;
    repeat (2) @(negedge clk);
    if (ipl_n !== 3'b010) report_value("ipl_n", 32'(ipl_n), 32'(3'b010));
    dma_done = 1'b1;
    repeat (2) @(negedge clk);
    if (ipl_n !== 3'b001) report_value("ipl_n", 32'(ipl_n), 32'(3'b001));
    dma_done = 1'b0;
    ack_irq(3'd6);
    if (ipl_n !== 3'b010) report_value("ipl_n", 32'(ipl_n), 32'(3'b010));
    ack_irq(3'd5);
    if (ipl_n !== 3'b111) report_value("ipl_n", 32'(ipl_n), 32'(3'b111));
    report_test("interrupts", start_errors);
endtask

task automatic unmapped_read();
    logic [15:0] data;
    logic        req_before;
    int          start_errors;
    start_errors = errors + pending_errors;
    req_before   = sdr_req;
    bus_read(24'h501234, 2'b00, data);
    if (data !== 16'h0000) report_value("data_in", 32'(data), 32'h0);
    if (sdr_req !== req_before) begin
        $display("An SDRAM request toggled during a read from an unmapped page");
        errors++;
    end
    report_test("unmapped", start_errors);
endtask

`endif

// File: verification/tb_f2_cpu_bus.sv
`timescale 1ns/100ps

module tb_f2_cpu_bus
    import f2_bus_pkg::*;
    import f2_board_pkg::*;
();

    localparam board_map_t  MAP      = '{rom_page: 8'h00, work_page: 8'h10, io_page: 8'h30};
    localparam logic [26:0] ROM_BASE = 27'h0200000;

    // Tests need about 550 cycles at the longest SDRAM delays
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              reset;
    cpu_bus_t          cpu_bus;
    logic              vblank, dma_done;
    logic [7:0]        dswa, dswb, joystick_p1, joystick_p2;
    logic [1:0]        start, coin;
    logic [26:0]       sdr_addr;
    logic [1:0]        sdr_be;
    logic              sdr_req, sdr_ack;
    logic [DATA_W-1:0] sdr_q, data_in;
    logic              dtack_n;
    logic [2:0]        ipl_n;

    integer seed           = 32'hc491;
    int     errors         = 0;
    int     pending_errors = 0;  // Counted by the dtack monitor
    int     tests_failed   = 0;
    int     cycle_count    = 0;
    int     sdr_delay;

    f2_cpu_bus #(.BOARD_MAP(MAP), .ROM_SDR_BASE(ROM_BASE), .WORK_ADDR_W(15)) i_dut (.*);

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // SDRAM model answering each toggle after 1 to 8 cycles

    initial begin
        sdr_ack = 1'b0;
        sdr_q   = '0;
        forever begin
            @(negedge clk);
            if (sdr_req != sdr_ack) begin
                sdr_delay = ($random(seed) & 7) + 1;
                repeat (sdr_delay - 1) @(negedge clk);
                sdr_q   = sdr_addr[15:0] ^ 16'h5a5a;
                sdr_ack = sdr_req;  // Data valid before the ack flips
            end
        end
    end

    // Values before the edge are settled since the falling edge
    always @(posedge clk) begin
        if (!reset && !dtack_n && sdr_req != sdr_ack) begin
            $display("dtack_n went low at cycle %0d while an SDRAM request was pending",
                     cycle_count);
            pending_errors <= pending_errors + 1;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        reset    = 1'b1;
        cpu_bus  = '{addr: '0, ds_n: 2'b11, rw: 1'b1, as_n: 1'b1, fc: 3'b000, wdata: '0};
        vblank   = 1'b0;
        dma_done = 1'b0;
        {dswa, dswb, joystick_p1, joystick_p2, start, coin} = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        work_ram_round_trip();
        rom_reads();
        io_register_reads();
        interrupt_priority();
        unmapped_read();

        $display("Summary: %0d of 5 tests failed, %0d errors", tests_failed,
                 errors + pending_errors);
        if (errors + pending_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/f2_cpu_bus.sv
`timescale 1ns/100ps

module f2_cpu_bus
    import f2_bus_pkg::*;
    import f2_board_pkg::*;
#(
    parameter board_map_t  BOARD_MAP    = DEFAULT_MAP,
    parameter logic [26:0] ROM_SDR_BASE = 27'h0200000,
    parameter int          WORK_ADDR_W  = 15
) (
    input  logic              clk,
    input  logic              reset,

    input  cpu_bus_t          cpu_bus,
    input  logic              vblank,
    input  logic              dma_done,

    input  logic [7:0]        dswa,
    input  logic [7:0]        dswb,
    input  logic [7:0]        joystick_p1,
    input  logic [7:0]        joystick_p2,
    input  logic [1:0]        start,
    input  logic [1:0]        coin,

    output logic [26:0]       sdr_addr,
    output logic [1:0]        sdr_be,
    output logic              sdr_req,
    input  logic              sdr_ack,
    input  logic [DATA_W-1:0] sdr_q,

    output logic [DATA_W-1:0] data_in,
    output logic              dtack_n,
    output logic [2:0]        ipl_n
);

    chip_sel_t         sel;
    logic [DATA_W-1:0] rom_data;
    logic [DATA_W-1:0] ram_data;
    logic [DATA_W-1:0] io_data;
    logic              rom_wait;

    address_decoder #(.BOARD_MAP(BOARD_MAP)) i_decoder (
        .bus (cpu_bus),
        .sel (sel)
    );

    rom_fetch #(.ROM_SDR_BASE(ROM_SDR_BASE)) i_rom_fetch (
        .clk      (clk),
        .reset    (reset),
        .bus      (cpu_bus),
        .sel      (sel),
        .sdr_addr (sdr_addr),
        .sdr_be   (sdr_be),
        .sdr_req  (sdr_req),
        .sdr_ack  (sdr_ack),
        .sdr_q    (sdr_q),
        .rom_data (rom_data),
        .rom_wait (rom_wait)
    );

    work_ram #(.WORK_ADDR_W(WORK_ADDR_W)) i_work_ram (
        .clk (clk),
        .bus (cpu_bus),
        .sel (sel),
        .q   (ram_data)
    );

    io_ports i_io_ports (
        .clk         (clk),
        .bus         (cpu_bus),
        .dswa        (dswa),
        .dswb        (dswb),
        .joystick_p1 (joystick_p1),
        .joystick_p2 (joystick_p2),
        .start       (start),
        .coin        (coin),
        .q           (io_data)
    );

    interrupt_controller i_irq (
        .clk      (clk),
        .reset    (reset),
        .bus      (cpu_bus),
        .sel      (sel),
        .vblank   (vblank),
        .dma_done (dma_done),
        .ipl_n    (ipl_n)
    );

    bus_response i_response (
        .clk      (clk),
        .bus      (cpu_bus),
        .sel      (sel),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .io_data  (io_data),
        .rom_wait (rom_wait),
        .data_in  (data_in),
        .dtack_n  (dtack_n)
    );

endmodule

// File: rtl/bus_response.sv
`timescale 1ns/100ps

module bus_response
    import f2_bus_pkg::*;
(
    input  logic              clk,
    input  cpu_bus_t          bus,
    input  chip_sel_t         sel,
    input  logic [DATA_W-1:0] rom_data,
    input  logic [DATA_W-1:0] ram_data,
    input  logic [DATA_W-1:0] io_data,
    input  logic              rom_wait,
    output logic [DATA_W-1:0] data_in,
    output logic              dtack_n
);

    logic strobe_low;
    logic strobe_low_prev;

    assign strobe_low = ~(&bus.ds_n);

    always_ff @(posedge clk) begin
        strobe_low_prev <= strobe_low;
    end

    //////////////////////////////////////////////////
    // Read data

    always_comb begin
        if (sel.rom) begin
            data_in = rom_data;
        end else if (sel.work) begin
            data_in = ram_data;
        end else if (sel.io) begin
            data_in = io_data;
        end else begin
            data_in = '0;  // Unmapped
        end
    end

    //////////////////////////////////////////////////
    // Transfer acknowledge

    // Strobes rising end the cycle at once
    assign dtack_n = ~(strobe_low & strobe_low_prev & ~rom_wait);

endmodule

// File: rtl/interrupt_controller.sv
`timescale 1ns/100ps

module interrupt_controller
    import f2_bus_pkg::*;
    import f2_board_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  cpu_bus_t   bus,
    input  chip_sel_t  sel,
    input  logic       vblank,
    input  logic       dma_done,
    output logic [2:0] ipl_n
);

    logic vblank_prev;
    logic dma_prev;
    logic vblank_req;
    logic dma_req;
    logic ack_cycle;

    assign ack_cycle = sel.irq_ack & ~bus.ds_n[0];

    always_ff @(posedge clk) begin
        vblank_prev <= vblank;
        dma_prev    <= dma_done;

        if (reset) begin
            vblank_req <= 1'b0;
            dma_req    <= 1'b0;
        end else begin
            if (vblank_prev & ~vblank) begin
                vblank_req <= 1'b1;
            end
            if (~dma_prev & dma_done) begin
                dma_req <= 1'b1;
            end

            // Clear wins over a set in the same cycle
            if (ack_cycle && bus.addr[2:0] == IRQ_VBLANK_LEVEL) begin
                vblank_req <= 1'b0;
            end
            if (ack_cycle && bus.addr[2:0] == IRQ_DMA_LEVEL) begin
                dma_req <= 1'b0;
            end
        end
    end

    assign ipl_n = dma_req    ? ~IRQ_DMA_LEVEL :
                   vblank_req ? ~IRQ_VBLANK_LEVEL :
                   3'b111;

endmodule

// File: rtl/io_ports.sv
`timescale 1ns/100ps

module io_ports
    import f2_bus_pkg::*;
    import f2_board_pkg::*;
(
    input  logic              clk,
    input  cpu_bus_t          bus,
    input  logic [7:0]        dswa,
    input  logic [7:0]        dswb,
    input  logic [7:0]        joystick_p1,
    input  logic [7:0]        joystick_p2,
    input  logic [1:0]        start,
    input  logic [1:0]        coin,
    output logic [DATA_W-1:0] q
);

    logic [7:0] reg_val;

    always_comb begin
        case (bus.addr[2:0])
            IO_DSWA: reg_val = dswa;
            IO_DSWB: reg_val = dswb;
            IO_P1:   reg_val = {start[0], joystick_p1[6:4],
                                joystick_p1[0], joystick_p1[1], joystick_p1[2], joystick_p1[3]};
            IO_P2:   reg_val = {start[1], joystick_p2[6:4],
                                joystick_p2[0], joystick_p2[1], joystick_p2[2], joystick_p2[3]};
            IO_COIN: reg_val = {4'b0000, coin, 2'b00};
            default: reg_val = 8'h00;  // Reads back as ff
        endcase
    end

    // Inputs are active low on the bus
    always_ff @(posedge clk) begin
        q <= {8'h00, ~reg_val};
    end

endmodule

// File: rtl/work_ram.sv
`timescale 1ns/100ps

module work_ram
    import f2_bus_pkg::*;
#(
    parameter int WORK_ADDR_W = 15
) (
    input  logic              clk,
    input  cpu_bus_t          bus,
    input  chip_sel_t         sel,
    output logic [DATA_W-1:0] q
);

    logic [1:0][7:0] mem [2**WORK_ADDR_W];

    logic [WORK_ADDR_W-1:0] addr;
    logic                   we_hi;
    logic                   we_lo;

    assign addr  = bus.addr[WORK_ADDR_W-1:0];
    assign we_hi = sel.work & ~bus.rw & ~bus.ds_n[1];
    assign we_lo = sel.work & ~bus.rw & ~bus.ds_n[0];

    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[addr][1] <= bus.wdata[15:8];
        end
        if (we_lo) begin
            mem[addr][0] <= bus.wdata[7:0];
        end
        q <= mem[addr];  // Read every cycle
    end

endmodule

// File: rtl/rom_fetch.sv
`timescale 1ns/100ps

module rom_fetch
    import f2_bus_pkg::*;
#(
    parameter logic [26:0] ROM_SDR_BASE = 27'h0000000
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_bus_t          bus,
    input  chip_sel_t         sel,
    output logic [26:0]       sdr_addr,
    output logic [1:0]        sdr_be,
    output logic              sdr_req,
    input  logic              sdr_ack,
    input  logic [DATA_W-1:0] sdr_q,
    output logic [DATA_W-1:0] rom_data,
    output logic              rom_wait
);

    logic strobes_idle_prev;  // Both strobes high last cycle
    logic start;
    logic pending;

    assign start   = sel.rom & ~(&bus.ds_n) & strobes_idle_prev;
    assign pending = sdr_req != sdr_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            strobes_idle_prev <= 1'b1;
            sdr_req           <= 1'b0;
        end else begin
            strobes_idle_prev <= &bus.ds_n;
            if (start) begin
                sdr_req <= ~sdr_req;  // One toggle per access
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdr_addr <= ROM_SDR_BASE + {3'b000, bus.addr, 1'b0};
            sdr_be   <= ~bus.ds_n;
        end
    end

    // Wait covers the strobe edge cycle before the toggle lands
    assign rom_wait = pending | start;
    assign rom_data = sdr_q;

endmodule

// File: rtl/address_decoder.sv
`timescale 1ns/100ps

module address_decoder
    import f2_bus_pkg::*;
    import f2_board_pkg::*;
#(
    parameter board_map_t BOARD_MAP = DEFAULT_MAP
) (
    input  cpu_bus_t  bus,
    output chip_sel_t sel
);

    logic [7:0] page;
    logic       active;
    logic       iack;

    assign page   = bus.addr[ADDR_W-1 -: 8];  // Byte address 23:16
    assign active = ~bus.as_n;
    assign iack   = active & (&bus.fc);

    always_comb begin
        sel = '0;
        if (iack) begin
            // Acknowledge cycles never reach memory
            sel.irq_ack = 1'b1;
        end else if (active) begin
            if (page == BOARD_MAP.rom_page) begin
                sel.rom = 1'b1;
            end else if (page == BOARD_MAP.work_page) begin
                sel.work = 1'b1;
            end else if (page == BOARD_MAP.io_page) begin
                sel.io = 1'b1;
            end
        end
    end

endmodule

// File: rtl/f2_board_pkg.sv
package f2_board_pkg;

    //////////////////////////////////////////////////
    // Memory map

    // Pages match byte address bits 23:16
    typedef struct packed {
        logic [7:0] rom_page;
        logic [7:0] work_page;
        logic [7:0] io_page;
    } board_map_t;

    localparam board_map_t DEFAULT_MAP = '{
        rom_page:  8'h00,
        work_page: 8'h10,
        io_page:   8'h30
    };

    //////////////////////////////////////////////////
    // Interrupt levels

    localparam logic [2:0] IRQ_VBLANK_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL    = 3'd6;

    //////////////////////////////////////////////////
    // Input register indices

    typedef enum logic [2:0] {
        IO_DSWA = 3'd0,
        IO_DSWB = 3'd1,
        IO_P1   = 3'd2,
        IO_P2   = 3'd3,
        IO_COIN = 3'd4
    } io_reg_e;

endpackage

// File: rtl/f2_bus_pkg.sv
package f2_bus_pkg;

    //////////////////////////////////////////////////
    // CPU bus widths

    localparam int ADDR_W = 23;  // Word address, byte address is 24 bits
    localparam int DATA_W = 16;

    //////////////////////////////////////////////////
    // Bus request from the 68000 side

    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // Word address
        logic [1:0]        ds_n;   // 1 upper, 0 lower
        logic              rw;     // 1 read, 0 write
        logic              as_n;
        logic [2:0]        fc;
        logic [DATA_W-1:0] wdata;
    } cpu_bus_t;

    // Active high selects, at most one set
    typedef struct packed {
        logic rom;
        logic work;
        logic io;
        logic irq_ack;  // Function code all ones
    } chip_sel_t;

endpackage
